/* build.f */
+incdir+common
common/isaPkg.sv
common/cpuPkg.sv
control/ctrlDecoder.sv
source/fetchUnit.sv
source/regFile.sv
source/execUnit.sv
source/dataMemory.sv
source/mipsCore.sv
tb/core_asserts.sv
tb/tbCore.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbCore -f build.f -o simv \
	&& ./obj_dir/simv | tee sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb/tbCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tbCore;

	localparam int ProgN = 200;
	localparam int Pre = 9;
	localparam int MaxCycles = 2000;
	localparam int DmAw = $clog2(`CPU_DM_WORDS);
	localparam logic [31:0] SentinelPc = `CPU_RESET_PC + 32'(4 * ProgN);

	logic                   clk;
	logic                   rst;
	logic [`CPU_DATA_W-1:0] pc;
	logic [`CPU_DATA_W-1:0] instr;
	cpuPkg::regTraceT       regTrace;
	cpuPkg::memTraceT       memTrace;

	logic [31:0] prog [0:ProgN];
	int          landing [0:ProgN];
	logic [31:0] mregs [32];
	logic [31:0] mdata [`CPU_DM_WORDS];
	logic [31:0] modelPc;

	mipsCore dut (
		.clk(clk), .rst(rst), .pc(pc), .instr(instr),
		.regTrace(regTrace), .memTrace(memTrace)
	);

	always #4 clk = ~clk;

	////////////////////
	// Program image
	////////////////////

	// Outside the image reads as an unused opcode and acts as a no-op
	function automatic logic [31:0] progWord(logic [31:0] addr);
		logic [31:0] off;
		int          idx;
		off = addr - `CPU_RESET_PC;
		idx = int'(off >> 2);
		if (addr < `CPU_RESET_PC || idx > ProgN || off[1:0] != 2'b00) begin
			return 32'hffff_ffff;
		end
		return prog[idx];
	endfunction

	assign instr = progWord(pc);

	function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
			logic [4:0] sh, logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encJ(logic [5:0] op, int idx);
		logic [31:0] target;
		target = `CPU_RESET_PC + 32'(4 * idx);
		return {op, target[27:2]};
	endfunction

	// Forward target that never lands inside a lui/ori/jr group
	function automatic int fwdTarget(int from);
		int t;
		t = from + 1 + int'($urandom % 6);
		if (t > ProgN) begin
			t = ProgN;
		end
		return landing[t];
	endfunction

	// Built from the end so every forward target already exists
	task automatic genProgram();
		int          i;
		int          kind;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] memOff;
		logic [31:0] target;
		for (int k = 0; k <= ProgN; k++) begin
			landing[k] = k;
		end
		prog[ProgN] = encJ(6'h02, ProgN);
		// Base register 28 and a zeroed window of eight words
		prog[0] = encI(6'h0d, 5'd0, 5'd28, 16'h0100);
		for (int w = -4; w < 4; w++) begin
			prog[w + 5] = encI(6'h2b, 5'd28, 5'd0, 16'(w * 4));
		end
		i = ProgN - 1;
		while (i >= Pre) begin
			kind = int'($urandom % 12);
			rs = 5'($urandom % 32);
			rt = 5'($urandom % 32);
			rd = 5'($urandom % 28);
			memOff = 16'((int'($urandom % 8) - 4) * 4);
			case (kind)
				0: prog[i] = encR(rs, rt, rd, 5'd0, 6'h20);
				1: prog[i] = encR(rs, rt, rd, 5'd0, 6'h22);
				2: prog[i] = encR(5'd0, rt, rd, 5'($urandom % 32), 6'h00);
				3: prog[i] = encI(6'h0d, rs, rd, 16'($urandom));
				4: prog[i] = encI(6'h0f, 5'd0, rd, 16'($urandom));
				5: prog[i] = encI(6'h23, 5'd28, rd, memOff);
				6: prog[i] = encI(6'h2b, 5'd28, rt, memOff);
				7: begin
					// Equal operands about half the time
					if ($urandom % 2 == 1) begin
						rt = rs;
					end
					prog[i] = encI(6'h04, rs, rt, 16'(fwdTarget(i) - i - 1));
				end
				8: prog[i] = encJ(6'h02, fwdTarget(i));
				9: prog[i] = encJ(6'h03, fwdTarget(i));
				default: begin
					if (i - 2 >= Pre) begin
						target = `CPU_RESET_PC + 32'(4 * fwdTarget(i));
						prog[i - 2] = encI(6'h0f, 5'd0, 5'd29, target[31:16]);
						prog[i - 1] = encI(6'h0d, 5'd29, 5'd29, target[15:0]);
						if (kind == 10) begin
							prog[i] = encR(5'd29, 5'd0, 5'd0, 5'd0, 6'h08);
						end else begin
							prog[i] = encR(5'd29, 5'd0, rd, 5'd0, 6'h09);
						end
						landing[i - 1] = i - 2;
						landing[i] = i - 2;
						i -= 2;
					end else begin
						prog[i] = encR(rs, rt, rd, 5'd0, 6'h20);
					end
				end
			endcase
			i--;
		end
	endtask

	////////////////////
	// Checking
	////////////////////

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			abortRun($sformatf("error at %0t ns: %s expected %h, got %h", $time, name, exp, got));
		end
	endtask

	// ISA reference for one instruction and its commit
	task automatic stepModel();
		logic [31:0] ins;
		logic [31:0] pc4;
		logic [31:0] rsV;
		logic [31:0] rtV;
		logic [31:0] sext;
		logic [31:0] res;
		logic [31:0] npc;
		logic [4:0]  dst;
		logic        wr;
		logic        mw;
		ins = progWord(modelPc);
		pc4 = modelPc + 32'd4;
		rsV = mregs[ins[25:21]];
		rtV = mregs[ins[20:16]];
		sext = {{16{ins[15]}}, ins[15:0]};
		npc = pc4;
		res = '0;
		dst = ins[20:16];
		wr = 1'b0;
		mw = 1'b0;
		case (ins[31:26])
			6'h00: begin
				dst = ins[15:11];
				wr = (ins[5:0] == 6'h20 || ins[5:0] == 6'h22 || ins[5:0] == 6'h00
					|| ins[5:0] == 6'h09);
				case (ins[5:0])
					6'h20: res = rsV + rtV;
					6'h22: res = rsV - rtV;
					6'h00: res = rtV << ins[10:6];
					6'h08: npc = rsV;
					6'h09: begin
						res = pc4;
						npc = rsV;
					end
					default: ;
				endcase
			end
			6'h0d: begin
				wr = 1'b1;
				res = rsV | {16'h0000, ins[15:0]};
			end
			6'h0f: begin
				wr = 1'b1;
				res = {ins[15:0], 16'h0000};
			end
			6'h23: begin
				wr = 1'b1;
				res = mdata[(rsV + sext) >> 2 & 32'(`CPU_DM_WORDS - 1)];
			end
			6'h2b: mw = 1'b1;
			6'h04: npc = (rsV == rtV) ? pc4 + {sext[29:0], 2'b00} : pc4;
			6'h02: npc = {modelPc[31:28], ins[25:0], 2'b00};
			6'h03: begin
				wr = 1'b1;
				dst = 5'(`CPU_RA);
				res = pc4;
				npc = {modelPc[31:28], ins[25:0], 2'b00};
			end
			default: ;
		endcase
		checkVal("regTrace.strobe", 32'(regTrace.strobe), 32'(wr));
		checkVal("memTrace.strobe", 32'(memTrace.strobe), 32'(mw));
		if (wr) begin
			checkVal("regTrace.pc", regTrace.pc, modelPc);
			checkVal("regTrace.idx", 32'(regTrace.idx), 32'(dst));
			checkVal("regTrace.data", regTrace.data, res);
			if (dst != 5'd0) begin
				mregs[dst] = res;
			end
		end
		if (mw) begin
			checkVal("memTrace.pc", memTrace.pc, modelPc);
			checkVal("memTrace.addr", memTrace.addr, rsV + sext);
			checkVal("memTrace.data", memTrace.data, rtV);
			mdata[DmAw'((rsV + sext) >> 2)] = rtV;
		end
		modelPc = npc;
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int cycles;
		bit done;
		clk = 1'b0;
		rst = 1'b1;
		cycles = 0;
		done = 1'b0;
		void'($urandom(84));
		genProgram();
		for (int k = 0; k < 32; k++) begin
			mregs[k] = '0;
		end
		for (int k = 0; k < `CPU_DM_WORDS; k++) begin
			mdata[k] = '0;
		end
		modelPc = `CPU_RESET_PC;

		@(posedge clk);
		@(negedge clk);
		checkVal("pc", pc, `CPU_RESET_PC);
		checkVal("regTrace.strobe", 32'(regTrace.strobe), 32'd0);
		checkVal("memTrace.strobe", 32'(memTrace.strobe), 32'd0);
		@(posedge clk);
		#1 rst = 1'b0;

		// One model instruction per cycle until the sentinel
		while (!done) begin
			@(negedge clk);
			checkVal("pc", pc, modelPc);
			if (modelPc == SentinelPc) begin
				done = 1'b1;
			end else begin
				stepModel();
				cycles++;
				if (cycles >= MaxCycles) begin
					abortRun("Timeout: pc did not reach the sentinel within 2000 cycles");
				end
			end
		end

		if (dut.uAsserts.failCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module coreAsserts (
	input logic                   clk,
	input logic                   rst,
	input logic [`CPU_DATA_W-1:0] pc,
	input cpuPkg::regTraceT       regTrace,
	input cpuPkg::memTraceT       memTrace
);

	int failCount = 0;

	// A retired instruction writes a register or memory but never both
	exclusiveStrobes: assert property (@(posedge clk) !(regTrace.strobe && memTrace.strobe))
		else begin
			$error("register and memory trace strobes high in the same cycle");
			failCount++;
		end

	quietInReset: assert property (@(posedge clk) rst |-> !(regTrace.strobe || memTrace.strobe))
		else begin
			$error("trace strobe high while rst is high");
			failCount++;
		end

	// Before the first reset edge pc is still unknown
	pcAligned: assert property (@(posedge clk) rst || (pc[1:0] == 2'b00))
		else begin
			$error("pc %h is not word aligned", pc);
			failCount++;
		end

endmodule

bind mipsCore coreAsserts uAsserts (
	.clk(clk), .rst(rst), .pc(pc), .regTrace(regTrace), .memTrace(memTrace)
);

`default_nettype wire

/* source/mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module mipsCore (
	input  logic                   clk,
	input  logic                   rst,
	output logic [`CPU_DATA_W-1:0] pc,
	input  logic [`CPU_DATA_W-1:0] instr,
	output cpuPkg::regTraceT       regTrace,
	output cpuPkg::memTraceT       memTrace
);

	localparam int RegAw = $clog2(`CPU_REG_N);

	isaPkg::instrFieldsT    fields;
	isaPkg::ctrlT           ctrl;
	cpuPkg::fetchT          fetch;
	logic [`CPU_DATA_W-1:0] rsData;
	logic [`CPU_DATA_W-1:0] rtData;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic [`CPU_DATA_W-1:0] extImm;
	logic [`CPU_DATA_W-1:0] readData;
	logic                   equal;
	logic [RegAw-1:0]       wReg;
	logic [`CPU_DATA_W-1:0] wData;
	logic                   regWen;
	logic                   memWen;

	assign fields = isaPkg::instrFieldsT'(instr);
	assign pc     = fetch.pc;

	////////////////////
	// Blocks
	////////////////////

	ctrlDecoder uCtrl (.instr(fields), .ctrl(ctrl));

	fetchUnit uFetch (
		.clk(clk), .rst(rst), .npcSel(ctrl.npcSel), .equal(equal),
		.imm16(fields.i.imm16), .index26(fields.j.index26), .rsData(rsData),
		.pc(fetch.pc), .pcPlus4(fetch.pcPlus4)
	);

	regFile uRegs (
		.clk(clk), .rst(rst), .rsAddr(fields.r.rs), .rtAddr(fields.r.rt),
		.rsData(rsData), .rtData(rtData), .wen(regWen), .wAddr(wReg), .wData(wData)
	);

	execUnit uExec (
		.ctrl(ctrl), .rsData(rsData), .rtData(rtData), .imm16(fields.i.imm16),
		.shamt(fields.r.shamt), .aluResult(aluResult), .extImm(extImm), .equal(equal)
	);

	dataMemory uDmem (
		.clk(clk), .rst(rst), .addr(aluResult), .wen(memWen), .wData(rtData), .rData(readData)
	);

	////////////////////
	// Writeback muxes
	////////////////////

	always_comb begin
		case (ctrl.regDst)
			isaPkg::dstRd: wReg = fields.r.rd;
			isaPkg::dstRa: wReg = RegAw'(`CPU_RA);
			default:       wReg = fields.r.rt;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			isaPkg::wbMem:   wData = readData;
			isaPkg::wbLink:  wData = fetch.pcPlus4;
			isaPkg::wbUpper: wData = {extImm[15:0], {(`CPU_DATA_W-16){1'b0}}};
			default:         wData = aluResult;
		endcase
	end

	// Writes and strobes held low in reset
	assign regWen = ctrl.regWrite && !rst;
	assign memWen = ctrl.memWrite && !rst;

	assign regTrace = '{strobe: regWen, pc: fetch.pc, idx: wReg, data: wData};
	assign memTrace = '{strobe: memWen, pc: fetch.pc, addr: aluResult, data: rtData};

endmodule

`default_nettype wire

/* source/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module dataMemory #(
	parameter int WordAw = $clog2(`CPU_DM_WORDS)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CPU_DATA_W-1:0] addr,
	input  logic                   wen,
	input  logic [`CPU_DATA_W-1:0] wData,
	output logic [`CPU_DATA_W-1:0] rData
);

	logic [`CPU_DATA_W-1:0] mem [`CPU_DM_WORDS];
	logic [WordAw-1:0]      wordIdx;

	// Byte address to word index, wraps at the depth
	assign wordIdx = addr[WordAw+1:2];

	assign rData = mem[wordIdx];

	// Contents survive reset, only the write is held off
	always_ff @(posedge clk) begin
		if (wen && !rst) begin
			mem[wordIdx] <= wData;
		end
	end

endmodule

`default_nettype wire

/* source/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execUnit (
	input  isaPkg::ctrlT           ctrl,
	input  logic [`CPU_DATA_W-1:0] rsData,
	input  logic [`CPU_DATA_W-1:0] rtData,
	input  logic [15:0]            imm16,
	input  logic [4:0]             shamt,
	output logic [`CPU_DATA_W-1:0] aluResult,
	output logic [`CPU_DATA_W-1:0] extImm,
	output logic                   equal
);

	logic [`CPU_DATA_W-1:0] opB;

	// Signed for lw and sw, zero filled otherwise
	assign extImm = ctrl.signExt ? {{(`CPU_DATA_W-16){imm16[15]}}, imm16}
	                             : {{(`CPU_DATA_W-16){1'b0}}, imm16};

	////////////////////
	// Operand B and ALU
	////////////////////

	always_comb begin
		case (ctrl.aluSrc)
			isaPkg::srcImm:   opB = extImm;
			isaPkg::srcShamt: opB = {{(`CPU_DATA_W-5){1'b0}}, shamt};
			default:          opB = rtData;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			isaPkg::aluSub: aluResult = rsData - opB;
			isaPkg::aluOr:  aluResult = rsData | opB;
			// sll shifts rt, not rs
			isaPkg::aluSll: aluResult = rtData << opB[4:0];
			default:        aluResult = rsData + opB;
		endcase
	end

	// beq compare only
	assign equal = (rsData == rtData);

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module regFile #(
	parameter int AddrW = $clog2(`CPU_REG_N)
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [AddrW-1:0]       rsAddr,
	input  logic [AddrW-1:0]       rtAddr,
	output logic [`CPU_DATA_W-1:0] rsData,
	output logic [`CPU_DATA_W-1:0] rtData,
	input  logic                   wen,
	input  logic [AddrW-1:0]       wAddr,
	input  logic [`CPU_DATA_W-1:0] wData
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];

	// Asynchronous reads, no write bypass
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wAddr != '0)) begin
			// Register 0 is never written and stays zero
			regs[wAddr] <= wData;
		end
	end

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module fetchUnit (
	input  logic                   clk,
	input  logic                   rst,
	input  isaPkg::npcSelE         npcSel,
	input  logic                   equal,
	input  logic [15:0]            imm16,
	input  logic [25:0]            index26,
	input  logic [`CPU_DATA_W-1:0] rsData,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic [`CPU_DATA_W-1:0] pcPlus4
);

	logic [`CPU_DATA_W-1:0] branchOffset;
	logic [`CPU_DATA_W-1:0] jumpTarget;
	logic [`CPU_DATA_W-1:0] nextPc;

	assign pcPlus4 = pc + `CPU_DATA_W'(4);

	// Word offset, sign extended
	assign branchOffset = {{(`CPU_DATA_W-18){imm16[15]}}, imm16, 2'b00};

	// Stays inside the current 256 MB region
	assign jumpTarget = {pc[`CPU_DATA_W-1 -: 4], index26, 2'b00};

	////////////////////
	// Next PC select
	////////////////////

	always_comb begin
		case (npcSel)
			isaPkg::npcBranch: nextPc = equal ? (pcPlus4 + branchOffset) : pcPlus4;
			isaPkg::npcJump:   nextPc = jumpTarget;
			isaPkg::npcReg:    nextPc = rsData;
			default:           nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

/* control/ctrlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder (
	input  isaPkg::instrFieldsT instr,
	output isaPkg::ctrlT        ctrl
);

	logic isR;
	logic isAdd;
	logic isSub;
	logic isSll;
	logic isJr;
	logic isJalr;
	logic isOri;
	logic isLw;
	logic isSw;
	logic isBeq;
	logic isLui;
	logic isJ;
	logic isJal;

	////////////////////
	// One-hot instruction flags
	////////////////////

	assign isR    = (instr.r.op == isaPkg::opRType);
	assign isAdd  = isR && (instr.r.funct == isaPkg::fnAdd);
	assign isSub  = isR && (instr.r.funct == isaPkg::fnSub);
	// Also matches the all-zero nop
	assign isSll  = isR && (instr.r.funct == isaPkg::fnSll);
	assign isJr   = isR && (instr.r.funct == isaPkg::fnJr);
	assign isJalr = isR && (instr.r.funct == isaPkg::fnJalr);

	assign isOri  = (instr.r.op == isaPkg::opOri);
	assign isLw   = (instr.r.op == isaPkg::opLw);
	assign isSw   = (instr.r.op == isaPkg::opSw);
	assign isBeq  = (instr.r.op == isaPkg::opBeq);
	assign isLui  = (instr.r.op == isaPkg::opLui);
	assign isJ    = (instr.r.op == isaPkg::opJ);
	assign isJal  = (instr.r.op == isaPkg::opJal);

	////////////////////
	// Control fields, bit by bit
	////////////////////

	// Unmatched encodings leave every bit low
	assign ctrl.regDst = isaPkg::regDstE'({isJal, isAdd | isSub | isSll | isJalr});

	assign ctrl.regWrite = isAdd | isSub | isOri | isLw | isLui | isJal | isSll | isJalr;

	assign ctrl.signExt = isLw | isSw;

	assign ctrl.aluSrc = isaPkg::aluSrcE'({isSll, isOri | isLw | isSw | isLui});

	assign ctrl.aluOp = isaPkg::aluOpE'({isOri | isSll, isSub | isSll});

	assign ctrl.memWrite = isSw;

	assign ctrl.wbSel = isaPkg::wbSelE'({isLui | isJal | isJalr, isLw | isLui});

	// Branch, register jump and plain jump share the two bits
	assign ctrl.npcSel = isaPkg::npcSelE'({isBeq | isJr | isJalr, isJal | isJ | isJr | isJalr});

endmodule

`default_nettype wire

/* common/cpuPkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpuPkg;

	localparam int RegAw = $clog2(`CPU_REG_N);

	// Fetch side of the datapath
	typedef struct packed {
		logic [`CPU_DATA_W-1:0] pc;
		logic [`CPU_DATA_W-1:0] pcPlus4;
	} fetchT;

	////////////////////
	// Retire trace records
	////////////////////

	// One register write per strobe
	typedef struct packed {
		logic                   strobe;
		logic [`CPU_DATA_W-1:0] pc;
		logic [RegAw-1:0]       idx;
		logic [`CPU_DATA_W-1:0] data;
	} regTraceT;

	// Byte address, always word aligned for sw
	typedef struct packed {
		logic                   strobe;
		logic [`CPU_DATA_W-1:0] pc;
		logic [`CPU_DATA_W-1:0] addr;
		logic [`CPU_DATA_W-1:0] data;
	} memTraceT;

endpackage

`default_nettype wire

/* common/isaPkg.sv */
`default_nettype none

package isaPkg;

	////////////////////
	// Instruction encodings
	////////////////////

	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeE;

	// Funct codes of the R group
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnJr   = 6'h08,
		fnJalr = 6'h09,
		fnAdd  = 6'h20,
		fnSub  = 6'h22
	} functE;

	// Three views of one instruction word
	typedef struct packed {
		opcodeE      op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		functE       funct;
	} rFmtT;

	typedef struct packed {
		opcodeE      op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFmtT;

	typedef struct packed {
		opcodeE      op;
		logic [25:0] index26;
	} jFmtT;

	typedef union packed {
		rFmtT r;
		iFmtT i;
		jFmtT j;
	} instrFieldsT;

	////////////////////
	// Control selectors
	////////////////////

	typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b10} regDstE;

	typedef enum logic [1:0] {wbAlu = 2'b00, wbMem = 2'b01, wbLink = 2'b10, wbUpper = 2'b11} wbSelE;

	typedef enum logic [1:0] {srcReg = 2'b00, srcImm = 2'b01, srcShamt = 2'b10} aluSrcE;

	typedef enum logic [1:0] {aluAdd = 2'b00, aluSub = 2'b01, aluOr = 2'b10, aluSll = 2'b11} aluOpE;

	// Jump shares the low bit with register jump
	typedef enum logic [1:0] {npcSeq = 2'b00, npcJump = 2'b01, npcBranch = 2'b10, npcReg = 2'b11} npcSelE;

	typedef struct packed {
		regDstE regDst;
		logic   regWrite;
		logic   signExt;
		aluSrcE aluSrc;
		aluOpE  aluOp;
		logic   memWrite;
		wbSelE  wbSel;
		npcSelE npcSel;
	} ctrlT;

endpackage

`default_nettype wire

/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////
// Datapath sizing
////////////////////

// Data and address width
`define CPU_DATA_W 32

// Architectural registers
`define CPU_REG_N 32

// Data RAM depth in words
`define CPU_DM_WORDS 1024

////////////////////
// Fixed addresses and indices
////////////////////

// First fetch after reset
`define CPU_RESET_PC 32'h0000_3000

// Link register for jal
`define CPU_RA 31

`endif
